//--- st_cfg_pkg.sv
package st_cfg_pkg;

  // machine model picked in the menu
  typedef enum logic [1:0] {
    st      = 2'd0,  // plain ST
    mega_st = 2'd1,  // adds blitter
    ste     = 2'd2   // blitter plus STE extras
  } chipset_t;

  // what drives ST joystick port 0
  typedef enum logic [1:0] {
    usb_mouse = 2'd0,  // HID mouse, DB9 left free for a joystick
    db9_atari = 2'd1,  // DB9 with Atari pinout
    db9_amiga = 2'd2,  // DB9 with Amiga pinout, two direction lines swapped
    none      = 2'd3   // port 0 idle
  } port_mouse_t;

  // output volume steps
  typedef enum logic [1:0] {
    mute    = 2'd0,
    quarter = 2'd1,  // >>> 2
    half    = 2'd2,  // >>> 1
    full    = 2'd3   // unscaled
  } volume_t;

  // wait for an sd image before booting anyway
  // 2 s at 32 MHz
  localparam int unsigned boot_wait_cycles = 64_000_000;

endpackage

//--- st_io_pkg.sv
package st_io_pkg;

  // joystick / mouse port bits
  // [5] fire2, [4] fire, [3:0] directions
  localparam int joy_w = 6;
  typedef logic [joy_w-1:0] joy_t;

  // keyboard matrix
  localparam int kbd_cols = 15;  // columns driven by the chipset
  localparam int kbd_rows = 8;
  typedef logic [kbd_rows-1:0] kbd_row_t;  // active-low key bits of one column

  // audio from the chipset mixer, 15 bit signed
  typedef logic signed [14:0] sample_in_t;
  // widened sample towards the dac
  typedef logic signed [15:0] sample_t;

  // ST word address, byte lane bit 0 not present
  typedef logic [23:1] ram_addr_t;

  // sd card side
  typedef logic [31:0] lba_t;       // sector number
  typedef logic [7:0]  sd_byte_t;   // one byte of sector data
  typedef logic [63:0] img_size_t;  // mounted image length, zero when none

endpackage

//--- input_mux.sv
module input_mux import st_cfg_pkg::*, st_io_pkg::*; (
  input  logic [5:0]  io,          // raw DB9 pins, active low
  input  port_mouse_t port_mouse,
  input  joy_t        hid_mouse,   // usb mouse, active high
  input  logic [7:0]  hid_joy,     // usb joystick, four dirs plus four buttons
  output joy_t        joy0,
  output logic [4:0]  joy1,
  output joy_t        db9_joy      // DB9 when used as joystick
);

  joy_t atari_map;  // pins decoded with Atari wiring
  joy_t amiga_map;  // pins decoded with Amiga wiring

  // invert and reorder pins
  // amiga mouse swaps the pins behind bits 3 and 0
  assign atari_map = ~{io[5], io[0], io[2], io[1], io[4], io[3]};
  assign amiga_map = ~{io[5], io[0], io[3], io[1], io[4], io[2]};

  // port 0 source
  // a DB9 mouse replaces the usb mouse instead of being ORed in,
  // mice hold some lines permanently active
  always_comb begin
    case (port_mouse)
      usb_mouse: joy0 = hid_mouse;
      db9_atari: joy0 = atari_map;
      db9_amiga: joy0 = amiga_map;
      default:   joy0 = '0;  // none
    endcase
  end

  // DB9 free for a joystick only while the mouse is on usb
  assign db9_joy = (port_mouse == usb_mouse) ? atari_map : '0;

  // port 1, usb and DB9 simply wired together
  assign joy1 = hid_joy[4:0] | db9_joy[4:0];

endmodule

//--- keyboard_matrix.sv
module keyboard_matrix import st_io_pkg::*; (
  input  kbd_row_t              keyboard [kbd_cols],  // per column key state from HID
  input  logic [kbd_cols-1:0]   matrix_out,           // column select, active low
  output kbd_row_t              matrix_in             // rows back to the chipset
);

  // AND over every selected column
  // a pressed key pulls its row low
  always_comb begin
    kbd_row_t acc;
    acc = '1;  // nothing selected reads as no key
    for (int c = 0; c < kbd_cols; c++) begin
      if (!matrix_out[c])
        acc = acc & keyboard[c];  // column driven low by scan
    end
    matrix_in = acc;
  end

endmodule

//--- audio_volume.sv
module audio_volume import st_cfg_pkg::*, st_io_pkg::*; (
  input  logic       clk32,
  input  logic       rst,
  input  volume_t    volume,
  input  logic       audio_in_valid,
  output logic       audio_in_ready,
  input  sample_in_t audio_in_l,
  input  sample_in_t audio_in_r,
  output logic       audio_out_valid,
  input  logic       audio_out_ready,
  output sample_t    audio_out_l,
  output sample_t    audio_out_r
);

  logic take;  // input transfer this cycle

  // widen to 16 bit and scale
  // signed shift keeps the sign bit
  function automatic sample_t scale(input sample_in_t s, input volume_t v);
    sample_t x;
    x = {s[14], s};  // sign extend
    case (v)
      mute:    scale = '0;
      quarter: scale = x >>> 2;
      half:    scale = x >>> 1;
      default: scale = x;  // full
    endcase
  endfunction

  // room when empty or when the held pair leaves now
  assign audio_in_ready = !audio_out_valid || audio_out_ready;
  assign take           = audio_in_valid && audio_in_ready;

  // output valid flag
  always_ff @(posedge clk32) begin
    if (rst) begin
      audio_out_valid <= 1'b0;
    end else if (take) begin
      audio_out_valid <= 1'b1;  // refilled, even when emptied this cycle
    end else if (audio_out_ready) begin
      audio_out_valid <= 1'b0;  // drained
    end
  end

  // payload, volume taken at acceptance
  always_ff @(posedge clk32) begin
    if (take) begin
      audio_out_l <= scale(audio_in_l, volume);
      audio_out_r <= scale(audio_in_r, volume);
    end
  end

endmodule

//--- ram_scrambler.sv
module ram_scrambler import st_io_pkg::*; (
  input  logic        clk32,
  input  logic        rst,
  input  logic        coldboot,    // cold boot request level from the menu
  input  ram_addr_t   ram_addr,    // chipset word address
  input  logic        ras_n,
  output logic [22:1] ram_addr_s,  // 22 bit word address to sdram
  output logic        ram_cs
);

  logic       coldboot_d;  // previous coldboot
  logic [1:0] scramble;    // cold boot count, wraps

  // each new cold boot request moves the address map,
  // so whatever was in ram looks like garbage afterwards
  always_ff @(posedge clk32) begin
    if (rst) begin
      coldboot_d <= 1'b0;
      scramble   <= 2'd0;
    end else begin
      coldboot_d <= coldboot;
      if (coldboot && !coldboot_d)
        scramble <= scramble + 2'd1;  // rising edge
    end
  end

  // bits 4:3 flipped by count, rest straight
  assign ram_addr_s = {ram_addr[22:5], ram_addr[4:3] ^ scramble, ram_addr[2:1]};

  // upper 8 MB not backed by sdram
  assign ram_cs = !ras_n && !ram_addr[23];

endmodule

//--- boot_gate.sv
module boot_gate import st_cfg_pkg::*, st_io_pkg::*; #(
  parameter int unsigned wait_cycles = boot_wait_cycles
) (
  input  logic      clk32,
  input  logic      rst,
  input  logic      sys_reset,     // reset from the menu
  input  logic      reset_button,
  input  logic      ram_ready,     // sdram init done
  input  logic      flash_ready,   // flash init done
  input  img_size_t img_size,      // nonzero once an sd image is mounted
  output logic      sd_ready,
  output logic      core_reset
);

  logic [31:0] wait_cnt;  // cycles since reset

  // give the mcu time to mount a default image
  // release on a mounted image or on timeout
  always_ff @(posedge clk32) begin
    if (rst) begin
      wait_cnt <= '0;
      sd_ready <= 1'b0;
    end else if (!sd_ready) begin
      if (img_size != '0)
        sd_ready <= 1'b1;  // image there, boot early
      if (wait_cnt < wait_cycles) begin
        wait_cnt <= wait_cnt + 32'd1;
      end else begin
        sd_ready <= 1'b1;  // timeout, boot without image
      end
    end
  end

  // ST held in reset while anything is not ready
  assign core_reset = rst
                   || sys_reset
                   || reset_button
                   || !ram_ready
                   || !flash_ready
                   || !sd_ready;

endmodule

//--- sd_req_arbiter.sv
module sd_req_arbiter import st_io_pkg::*; (
  input  logic       clk32,
  input  logic       rst,
  input  logic [1:0] fdc_rd,        // floppy read strobe, per drive
  input  logic [1:0] fdc_wr,
  input  lba_t       fdc_lba,
  input  sd_byte_t   fdc_wr_byte,
  input  logic [1:0] acsi_rd,       // hard disk read strobe, per drive
  input  logic [1:0] acsi_wr,
  input  lba_t       acsi_lba,
  input  sd_byte_t   acsi_wr_byte,
  output logic [3:0] sd_rstart,
  output logic [3:0] sd_wstart,
  output lba_t       sd_lba,
  output sd_byte_t   sd_wr_byte
);

  logic acsi_req;   // any ACSI strobe now
  logic fdc_req;    // any floppy strobe now
  logic is_acsi_q;  // last request came from ACSI
  logic is_acsi;

  assign acsi_req = |acsi_rd || |acsi_wr;
  assign fdc_req  = |fdc_rd || |fdc_wr;

  // owner flag, held for the whole sector transfer
  always_ff @(posedge clk32) begin
    if (rst) begin
      is_acsi_q <= 1'b0;
    end else begin
      if (acsi_req)
        is_acsi_q <= 1'b1;
      if (fdc_req)
        is_acsi_q <= 1'b0;  // floppy wins a tie
    end
  end

  // request cycle already routed to ACSI
  assign is_acsi = acsi_req || is_acsi_q;

  // drives 0,1 floppy, 2,3 ACSI
  assign sd_rstart = {acsi_rd, fdc_rd};
  assign sd_wstart = {acsi_wr, fdc_wr};

  // sector number and write data follow the owner
  assign sd_lba     = is_acsi ? acsi_lba : fdc_lba;
  assign sd_wr_byte = is_acsi ? acsi_wr_byte : fdc_wr_byte;

endmodule

//--- st_glue.sv
module st_glue import st_cfg_pkg::*, st_io_pkg::*; #(
  parameter int unsigned wait_cycles = boot_wait_cycles
) (
  input  logic                clk32,
  input  logic                rst,
  // joystick ports
  input  logic [5:0]          io,
  input  port_mouse_t         port_mouse,
  input  joy_t                hid_mouse,
  input  logic [7:0]          hid_joy,
  output joy_t                joy0,
  output logic [4:0]          joy1,
  output joy_t                db9_joy,
  // keyboard
  input  kbd_row_t            keyboard [kbd_cols],
  input  logic [kbd_cols-1:0] matrix_out,
  output kbd_row_t            matrix_in,
  // audio stream
  input  volume_t             volume,
  input  logic                audio_in_valid,
  output logic                audio_in_ready,
  input  sample_in_t          audio_in_l,
  input  sample_in_t          audio_in_r,
  output logic                audio_out_valid,
  input  logic                audio_out_ready,
  output sample_t             audio_out_l,
  output sample_t             audio_out_r,
  // ram
  input  logic                coldboot,
  input  ram_addr_t           ram_addr,
  input  logic                ras_n,
  output logic [22:1]         ram_addr_s,
  output logic                ram_cs,
  // boot
  input  logic                sys_reset,
  input  logic                reset_button,
  input  logic                ram_ready,
  input  logic                flash_ready,
  input  img_size_t           img_size,
  output logic                sd_ready,
  output logic                core_reset,
  // sd requests
  input  logic [1:0]          fdc_rd,
  input  logic [1:0]          fdc_wr,
  input  lba_t                fdc_lba,
  input  sd_byte_t            fdc_wr_byte,
  input  logic [1:0]          acsi_rd,
  input  logic [1:0]          acsi_wr,
  input  lba_t                acsi_lba,
  input  sd_byte_t            acsi_wr_byte,
  output logic [3:0]          sd_rstart,
  output logic [3:0]          sd_wstart,
  output lba_t                sd_lba,
  output sd_byte_t            sd_wr_byte
);

  input_mux u_input_mux (
    .io, .port_mouse, .hid_mouse, .hid_joy,
    .joy0, .joy1, .db9_joy
  );

  keyboard_matrix u_keyboard_matrix (
    .keyboard, .matrix_out, .matrix_in
  );

  audio_volume u_audio_volume (
    .clk32, .rst, .volume,
    .audio_in_valid, .audio_in_ready, .audio_in_l, .audio_in_r,
    .audio_out_valid, .audio_out_ready, .audio_out_l, .audio_out_r
  );

  ram_scrambler u_ram_scrambler (
    .clk32, .rst, .coldboot, .ram_addr, .ras_n,
    .ram_addr_s, .ram_cs
  );

  // wait time shortened in simulation via the top parameter
  boot_gate #(
    .wait_cycles(wait_cycles)
  ) u_boot_gate (
    .clk32, .rst, .sys_reset, .reset_button, .ram_ready, .flash_ready,
    .img_size, .sd_ready, .core_reset
  );

  sd_req_arbiter u_sd_req_arbiter (
    .clk32, .rst,
    .fdc_rd, .fdc_wr, .fdc_lba, .fdc_wr_byte,
    .acsi_rd, .acsi_wr, .acsi_lba, .acsi_wr_byte,
    .sd_rstart, .sd_wstart, .sd_lba, .sd_wr_byte
  );

endmodule

//--- tb_st_glue.sv
module tb_st_glue import st_cfg_pkg::*, st_io_pkg::*;;

  // per-test cycle budgets, summed for the watchdog
  localparam int audio_limit     = 1000;
  localparam int joy_steps       = 64;
  localparam int kbd_steps       = 33;
  localparam int ram_steps       = 80;
  localparam int boot_steps      = 260;
  localparam int sd_steps        = 64;
  localparam int watchdog_cycles = 8 + audio_limit + joy_steps + kbd_steps + ram_steps
                                 + boot_steps + sd_steps + 500;  // margin

  logic clk32, rst;
  logic [5:0] io;
  port_mouse_t port_mouse;
  joy_t hid_mouse, joy0, db9_joy;
  logic [7:0] hid_joy;
  logic [4:0] joy1;
  kbd_row_t keyboard [kbd_cols];
  logic [kbd_cols-1:0] matrix_out;
  kbd_row_t matrix_in;
  volume_t volume;
  logic audio_in_valid, audio_in_ready, audio_out_valid, audio_out_ready;
  sample_in_t audio_in_l, audio_in_r;
  sample_t audio_out_l, audio_out_r;
  logic coldboot, ras_n, ram_cs;
  ram_addr_t ram_addr;
  logic [22:1] ram_addr_s;
  logic sys_reset, reset_button, ram_ready, flash_ready, sd_ready, core_reset;
  img_size_t img_size;
  logic [1:0] fdc_rd, fdc_wr, acsi_rd, acsi_wr;
  lba_t fdc_lba, acsi_lba, sd_lba;
  sd_byte_t fdc_wr_byte, acsi_wr_byte, sd_wr_byte;
  logic [3:0] sd_rstart, sd_wstart;

  integer seed;
  int value_errs, other_errs;
  logic [31:0] exp_q [$];  // expected {l, r} audio pairs

  st_glue #(.wait_cycles(200)) DUT (.*);

  initial begin
    clk32 = 1'b0;
    forever #50 clk32 = ~clk32;
  end

  function automatic logic [31:0] rand32();
    rand32 = $random(seed);
  endfunction

  // widen, then arithmetic shift per volume code
  function automatic logic [15:0] scale_ref(input logic [14:0] s, input logic [1:0] v);
    int x;
    x = {{17{s[14]}}, s};
    case (v)
      2'd0: x = 0;         // mute
      2'd1: x = x >>> 2;   // quarter
      2'd2: x = x >>> 1;   // half
      default: ;           // full
    endcase
    scale_ref = x[15:0];
  endfunction

  // DB9 pins to joy bits, active high
  function automatic logic [5:0] db9_ref(input logic [5:0] pins, input logic amiga);
    logic [5:0] p;
    p = ~pins;
    db9_ref[5] = p[5];                 // fire2
    db9_ref[4] = p[0];                 // fire
    db9_ref[3] = amiga ? p[3] : p[2];
    db9_ref[2] = p[1];
    db9_ref[1] = p[4];
    db9_ref[0] = amiga ? p[2] : p[3];  // swapped with bit 3 on amiga
  endfunction

  task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else begin
      $display("ERR %s expected %h got %h", name, exp, act);
      value_errs++;
    end
  endtask

  task automatic drive_slot();
    @(posedge clk32);
    #10;  // inputs change just after the edge
  endtask

  task automatic apply_reset();
    drive_slot();
    rst = 1'b1;
    repeat (8) @(posedge clk32);
    #10 rst = 1'b0;
  endtask

  task automatic test_audio();
    logic [31:0] r;
    logic [31:0] exp_pair;
    logic [15:0] held_l, held_r;
    logic in_fire, held, exp_full;
    int sent, got, cycles;
    sent = 0;
    got = 0;
    cycles = 0;
    in_fire = 1'b0;
    held = 1'b0;
    exp_full = 1'b0;  // output register empty after reset
    held_l = '0;
    held_r = '0;
    while (got < 64 && cycles < audio_limit) begin
      drive_slot();
      if (in_fire || !audio_in_valid) begin  // source free for a new sample
        if (sent < 64) begin
          r = rand32();
          audio_in_valid = 1'b1;
          audio_in_l = r[14:0];
          audio_in_r = r[29:15];
          volume = volume_t'(sent[1:0]);  // walk all four codes
          sent++;
        end else begin
          audio_in_valid = 1'b0;
        end
      end
      r = rand32();
      audio_out_ready = r[0];  // random back-pressure
      @(negedge clk32);
      if (held) begin
        assert (audio_out_valid && audio_out_l == held_l && audio_out_r == held_r) else begin
          $display("audio output changed while stalled");
          other_errs++;
        end
      end
      // one-slot occupancy, refilled in the cycle it drains
      check_val("audio_out_valid", {63'd0, exp_full}, {63'd0, audio_out_valid});
      check_val("audio_in_ready", {63'd0, !exp_full || audio_out_ready},
                {63'd0, audio_in_ready});
      in_fire = audio_in_valid && audio_in_ready;
      if (in_fire)
        exp_q.push_back({scale_ref(audio_in_l, volume), scale_ref(audio_in_r, volume)});
      if (audio_out_valid && audio_out_ready) begin
        assert (exp_q.size() > 0) else begin
          $display("audio output transfer with no sample sent");
          other_errs++;
        end
        if (exp_q.size() > 0) begin
          exp_pair = exp_q.pop_front();
          check_val("audio_out_l", {48'd0, exp_pair[31:16]}, {48'd0, audio_out_l});
          check_val("audio_out_r", {48'd0, exp_pair[15:0]}, {48'd0, audio_out_r});
        end
        got++;
      end
      exp_full = in_fire || (exp_full && !audio_out_ready);  // one cycle latency
      held = audio_out_valid && !audio_out_ready;
      held_l = audio_out_l;
      held_r = audio_out_r;
      cycles++;
    end
    assert (got == 64) else begin
      $display("audio stream delivered only %0d of 64 samples", got);
      other_errs++;
    end
    drive_slot();
    audio_in_valid = 1'b0;
    audio_out_ready = 1'b0;
  endtask

  task automatic test_joy();
    logic [31:0] r;
    logic [5:0] atari, amiga, exp0, exp_db9;
    for (int pm = 0; pm < 4; pm++) begin
      for (int i = 0; i < 16; i++) begin
        drive_slot();
        r = rand32();
        port_mouse = port_mouse_t'(pm[1:0]);
        io = r[5:0];
        hid_mouse = r[11:6];
        hid_joy = r[19:12];
        @(negedge clk32);
        atari = db9_ref(io, 1'b0);
        amiga = db9_ref(io, 1'b1);
        exp0 = (pm == 0) ? hid_mouse : (pm == 1) ? atari : (pm == 2) ? amiga : 6'd0;
        exp_db9 = (pm == 0) ? atari : 6'd0;  // DB9 joystick only with usb mouse
        check_val("joy0", {58'd0, exp0}, {58'd0, joy0});
        check_val("db9_joy", {58'd0, exp_db9}, {58'd0, db9_joy});
        check_val("joy1", {59'd0, hid_joy[4:0] | exp_db9[4:0]}, {59'd0, joy1});
      end
    end
  endtask

  task automatic test_kbd();
    logic [31:0] r;
    logic [7:0] exp;
    for (int i = 0; i < 33; i++) begin
      drive_slot();
      for (int c = 0; c < kbd_cols; c++) begin
        r = rand32();
        keyboard[c] = r[7:0] | r[15:8] | r[23:16];  // few keys down
      end
      r = rand32();
      matrix_out = (i == 32) ? '1 : (r[14:0] | r[29:15]);  // last round selects nothing
      @(negedge clk32);
      exp = '1;
      for (int b = 0; b < 8; b++)
        for (int c = 0; c < kbd_cols; c++)
          if (!matrix_out[c] && !keyboard[c][b])
            exp[b] = 1'b0;
      check_val("matrix_in", {56'd0, exp}, {56'd0, matrix_in});
    end
  endtask

  task automatic test_ram();
    logic [31:0] r;
    logic [22:1] exp_s;
    for (int k = 0; k < 6; k++) begin
      if (k > 0) begin  // one coldboot pulse
        drive_slot();
        coldboot = 1'b1;
        drive_slot();
        coldboot = 1'b0;
        drive_slot();
      end
      for (int i = 0; i < 8; i++) begin
        drive_slot();
        r = rand32();
        ram_addr = r[22:0];
        ras_n = r[23];
        @(negedge clk32);
        exp_s = ram_addr[22:1];
        exp_s[4:3] = exp_s[4:3] ^ k[1:0];  // pulse count mod 4
        check_val("ram_addr_s", {42'd0, exp_s}, {42'd0, ram_addr_s});
        check_val("ram_cs", {63'd0, !ras_n && !ram_addr[23]}, {63'd0, ram_cs});
      end
    end
  endtask

  task automatic test_boot();
    logic [31:0] r;
    int n;
    img_size = '0;
    apply_reset();
    n = 0;
    @(negedge clk32);
    while (!sd_ready && n <= 202) begin
      check_val("core_reset", 64'd1, {63'd0, core_reset});
      n++;
      @(negedge clk32);
    end
    assert (sd_ready) else begin
      $display("sd_ready not released within 202 cycles with no image");
      other_errs++;
    end
    check_val("core_reset", 64'd0, {63'd0, core_reset});
    for (int s = 0; s < 4; s++) begin  // one reset source at a time
      drive_slot();
      sys_reset = (s == 0);
      reset_button = (s == 1);
      ram_ready = (s != 2);
      flash_ready = (s != 3);
      @(negedge clk32);
      check_val("core_reset", 64'd1, {63'd0, core_reset});
    end
    drive_slot();
    sys_reset = 1'b0;
    reset_button = 1'b0;
    ram_ready = 1'b1;
    flash_ready = 1'b1;
    // second reset, image mounted right away
    apply_reset();
    r = rand32();
    img_size = {32'd0, r} | 64'd1;
    n = 0;
    @(negedge clk32);
    while (!sd_ready && n < 10) begin
      n++;
      @(negedge clk32);
    end
    assert (sd_ready) else begin
      $display("sd_ready not released early by a nonzero image size");
      other_errs++;
    end
  endtask

  task automatic test_sd();
    logic [31:0] r;
    logic [1:0] pick;
    logic acsi_own, acsi_now, fdc_now, use_acsi;
    acsi_own = 1'b0;  // cleared by the last reset
    for (int i = 0; i < 64; i++) begin
      drive_slot();
      r = rand32();
      pick = (r[4:3] == 2'd0) ? 2'd1 : r[4:3];  // nonzero drive bits
      fdc_rd = (r[2:0] == 3'd4) ? pick : 2'd0;
      fdc_wr = (r[2:0] == 3'd5) ? pick : 2'd0;
      acsi_rd = (r[2:0] == 3'd6) ? pick : 2'd0;
      acsi_wr = (r[2:0] == 3'd7) ? pick : 2'd0;
      fdc_lba = rand32();
      acsi_lba = rand32();
      r = rand32();
      fdc_wr_byte = r[7:0];
      acsi_wr_byte = r[15:8];
      @(negedge clk32);
      acsi_now = |acsi_rd || |acsi_wr;
      fdc_now = |fdc_rd || |fdc_wr;
      check_val("sd_rstart", {60'd0, acsi_rd, fdc_rd}, {60'd0, sd_rstart});
      check_val("sd_wstart", {60'd0, acsi_wr, fdc_wr}, {60'd0, sd_wstart});
      use_acsi = acsi_now || acsi_own;
      check_val("sd_lba", {32'd0, use_acsi ? acsi_lba : fdc_lba}, {32'd0, sd_lba});
      check_val("sd_wr_byte", {56'd0, use_acsi ? acsi_wr_byte : fdc_wr_byte},
                {56'd0, sd_wr_byte});
      if (acsi_now)
        acsi_own = 1'b1;  // owner from next cycle
      else if (fdc_now)
        acsi_own = 1'b0;
    end
  endtask

  initial begin
    #(watchdog_cycles * 100);
    $display("watchdog expired after %0d cycles, run did not finish", watchdog_cycles);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    seed = 32'h68bc_115e;
    value_errs = 0;
    other_errs = 0;
    rst = 1'b1;
    io = '1;  // pins idle high
    port_mouse = usb_mouse;
    hid_mouse = '0;
    hid_joy = '0;
    for (int c = 0; c < kbd_cols; c++)
      keyboard[c] = '1;
    matrix_out = '1;
    volume = full;
    audio_in_valid = 1'b0;
    audio_in_l = '0;
    audio_in_r = '0;
    audio_out_ready = 1'b0;
    coldboot = 1'b0;
    ram_addr = '0;
    ras_n = 1'b1;
    sys_reset = 1'b0;
    reset_button = 1'b0;
    ram_ready = 1'b1;
    flash_ready = 1'b1;
    img_size = '0;
    fdc_rd = '0;
    fdc_wr = '0;
    fdc_lba = '0;
    fdc_wr_byte = '0;
    acsi_rd = '0;
    acsi_wr = '0;
    acsi_lba = '0;
    acsi_wr_byte = '0;
    apply_reset();
    @(negedge clk32);
    check_val("audio_out_valid", 64'd0, {63'd0, audio_out_valid});
    check_val("sd_ready", 64'd0, {63'd0, sd_ready});
    check_val("core_reset", 64'd1, {63'd0, core_reset});
    test_audio();
    test_joy();
    test_kbd();
    test_ram();
    test_boot();
    test_sd();
    $display("checks done: %0d value errors, %0d other errors", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

//--- st_glue.f
st_cfg_pkg.sv
st_io_pkg.sv
input_mux.sv
keyboard_matrix.sv
audio_volume.sv
ram_scrambler.sv
boot_gate.sv
sd_req_arbiter.sv
st_glue.sv
tb_st_glue.sv

//--- Makefile
# Verilator build and run for the st_glue testbench

TOP := tb_st_glue
LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): st_glue.f $(wildcard *.sv)
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f st_glue.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

lint:
	verilator --lint-only -Wall --timing --top-module st_glue -f st_glue.f

clean:
	rm -rf obj_dir $(LOG)
